// ==== include/game_sdram_defines.svh ====
// SDRAM bank geometry, client slot count and ROM region base addresses
`ifndef GAME_SDRAM_DEFINES_SVH
`define GAME_SDRAM_DEFINES_SVH

// Bank word-address width
`define SDRAM_AW 22

// One SDRAM word
`define SDRAM_DW 16

// Clients sharing the bank read port
`define NUM_SLOTS 3

// Region offsets in SDRAM words
// Main CPU program ROM
`define MAIN_ROM_BASE 22'h00_0000

// Graphics ROM, two words per payload
`define GFX_ROM_BASE 22'h10_0000

// Sound PCM samples, two bytes per word
`define PCM_ROM_BASE 22'h30_0000

`endif

// ==== hw/sdram_pkg.sv ====
// Package sdram_pkg with the bank-side address, word and slot index types
`include "game_sdram_defines.svh"

package sdram_pkg;

    // Word address inside the bank
    typedef logic [`SDRAM_AW-1:0] sdram_addr_t;

    // Data word as read from the bank
    typedef logic [`SDRAM_DW-1:0] sdram_word_t;

    // Index of one client slot at the arbiter
    typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_id_t;

endpackage

// ==== hw/client_pkg.sv ====
// Package client_pkg with the ROM client payload and address types
`include "game_sdram_defines.svh"

package client_pkg;

    // Main CPU reads one SDRAM word at a time
    typedef logic [`SDRAM_DW-1:0] main_rom_data_t;

    // Graphics payload spans two SDRAM words
    typedef logic [2*`SDRAM_DW-1:0] gfx_rom_data_t;

    // PCM sample, one byte of a word
    typedef logic [7:0] pcm_data_t;

    // Counted in payloads, so a byte address for PCM
    typedef logic [`SDRAM_AW-2:0] client_addr_t;

endpackage

// ==== hw/sdram_slot.sv ====
// Module sdram_slot, a one-entry read cache in front of the SDRAM arbiter
`timescale 1ns/1ps
`include "game_sdram_defines.svh"

module sdram_slot
    import sdram_pkg::*;
    import client_pkg::*;
#(
    parameter type         payload_t   = logic [15:0],
    parameter sdram_addr_t region_base = '0
) (
    input  logic         VB,
    input  logic         reset,
    // Client side
    input  logic         cs,
    input  client_addr_t addr,
    output payload_t     data,
    output logic         ok,
    // Arbiter side
    output logic         req,
    output sdram_addr_t  req_addr,
    input  logic         word_valid,
    input  sdram_word_t  word_data,
    input  logic         done
);

    localparam int pw = $bits(payload_t);

    logic         cache_valid;
    client_addr_t cache_addr;
    payload_t     cache_data;
    client_addr_t fetch_addr;
    payload_t     fill_data;
    sdram_addr_t  word_offset;
    logic         hit;
    logic         start_fetch;
    logic         fetch_end;

    assign hit         = cache_valid && (cache_addr == addr);
    assign ok          = cs && hit;
    assign data        = cache_data;

    // A fetch in flight always runs to its end, then the compare starts over
    assign start_fetch = cs && !hit && !req;
    assign fetch_end   = req && word_valid && done;

    assign req_addr    = region_base + word_offset;

    always_ff @(posedge VB) begin
        if (reset) begin
            req         <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            if (start_fetch) begin
                req <= 1'b1;
            end else if (fetch_end) begin
                req         <= 1'b0;
                cache_valid <= 1'b1;
            end
        end
    end

    // Address is frozen for the whole fetch
    always_ff @(posedge VB) begin
        if (start_fetch) begin
            fetch_addr <= addr;
        end
        if (fetch_end) begin
            cache_addr <= fetch_addr;
            cache_data <= fill_data;
        end
    end

    // Word mapping and payload assembly depend on the payload width
    generate
        if (pw > `SDRAM_DW) begin : g_two_words
            sdram_word_t low_word;

            // Even word arrives first and fills the low half
            always_ff @(posedge VB) begin
                if (word_valid && !done) begin
                    low_word <= word_data;
                end
            end

            assign fill_data   = {word_data, low_word};
            assign word_offset = {fetch_addr, 1'b0};
        end else if (pw < `SDRAM_DW) begin : g_byte
            // Bit 0 picks the byte lane, the rest is the word index
            assign fill_data   = fetch_addr[0] ? word_data[15:8] : word_data[7:0];
            assign word_offset = sdram_addr_t'(fetch_addr[`SDRAM_AW-2:1]);
        end else begin : g_one_word
            assign fill_data   = word_data;
            assign word_offset = sdram_addr_t'(fetch_addr);
        end
    endgenerate

endmodule

// ==== hw/sdram_arbiter.sv ====
// Module sdram_arbiter, round-robin owner of the SDRAM bank read port
`timescale 1ns/1ps
`include "game_sdram_defines.svh"

module sdram_arbiter
    import sdram_pkg::*;
#(
    // Slots whose payload takes two SDRAM words
    parameter logic [`NUM_SLOTS-1:0] two_word_slots = '0
) (
    input  logic                  VB,
    input  logic                  reset,
    // Slot side
    input  logic [`NUM_SLOTS-1:0] req,
    input  sdram_addr_t           req_addr [`NUM_SLOTS],
    output logic [`NUM_SLOTS-1:0] word_valid,
    output logic [`NUM_SLOTS-1:0] done,
    output sdram_word_t           word_data,
    // Bank read port
    output sdram_addr_t           ba_addr,
    output logic                  ba_rd,
    input  logic                  ba_ack,
    input  logic                  ba_dok,
    input  logic                  ba_rdy,
    input  sdram_word_t           data_read
);

    typedef enum logic [1:0] {
        s_idle,
        s_ask,
        s_wait
    } state_t;

    state_t   state;
    slot_id_t grant;
    slot_id_t rr_ptr;
    slot_id_t pick;
    logic     pick_valid;
    logic     word_cnt;
    logic     last_word;

    // First requesting slot, searching from the round-robin pointer
    always_comb begin
        int unsigned idx;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            idx = (int'(rr_ptr) + i) % `NUM_SLOTS;
            if (!pick_valid && req[idx]) begin
                pick       = slot_id_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    assign last_word = !two_word_slots[grant] || word_cnt;
    assign ba_rd     = (state == s_ask);
    assign word_data = data_read;

    // Strobes reach the granted slot only
    always_comb begin
        word_valid = '0;
        done       = '0;
        if (state == s_wait) begin
            word_valid[grant] = ba_dok;
            done[grant]       = ba_rdy && last_word;
        end
    end

    always_ff @(posedge VB) begin
        if (reset) begin
            state    <= s_idle;
            grant    <= '0;
            rr_ptr   <= '0;
            word_cnt <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (pick_valid) begin
                        grant    <= pick;
                        word_cnt <= 1'b0;
                        state    <= s_ask;
                        if (pick == slot_id_t'(`NUM_SLOTS - 1)) begin
                            rr_ptr <= '0;
                        end else begin
                            rr_ptr <= pick + 1'b1;
                        end
                    end
                end
                s_ask: begin
                    if (ba_ack) begin
                        state <= s_wait;
                    end
                end
                s_wait: begin
                    if (ba_rdy) begin
                        if (last_word) begin
                            state <= s_idle;
                        end else begin
                            // Second graphics word is a request of its own
                            word_cnt <= 1'b1;
                            state    <= s_ask;
                        end
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // Bank address is loaded at grant and stepped for the second word
    always_ff @(posedge VB) begin
        if (state == s_idle && pick_valid) begin
            ba_addr <= req_addr[pick];
        end else if (state == s_wait && ba_rdy && !last_word) begin
            ba_addr <= ba_addr + 1'b1;
        end
    end

endmodule

// ==== hw/game_sdram.sv ====
// Module game_sdram, three ROM client slots sharing one SDRAM bank read port
`timescale 1ns/1ps
`include "game_sdram_defines.svh"

module game_sdram
    import sdram_pkg::*;
    import client_pkg::*;
(
    input  logic           VB,
    input  logic           reset,
    // Main CPU program ROM
    input  logic           main_rom_cs,
    input  client_addr_t   main_rom_addr,
    output main_rom_data_t main_rom_data,
    output logic           main_rom_ok,
    // Graphics ROM
    input  logic           gfx_rom_cs,
    input  client_addr_t   gfx_rom_addr,
    output gfx_rom_data_t  gfx_rom_data,
    output logic           gfx_rom_ok,
    // Sound PCM ROM
    input  logic           pcm_cs,
    input  client_addr_t   pcm_addr,
    output pcm_data_t      pcm_data,
    output logic           pcm_ok,
    // SDRAM bank read port
    output sdram_addr_t    ba_addr,
    output logic           ba_rd,
    input  logic           ba_ack,
    input  logic           ba_dok,
    input  logic           ba_rdy,
    input  sdram_word_t    data_read
);

    // Slot order at the arbiter
    localparam int main_slot = 0;
    localparam int gfx_slot  = 1;
    localparam int pcm_slot  = 2;

    localparam logic [`NUM_SLOTS-1:0] gfx_mask = `NUM_SLOTS'(1) << gfx_slot;

    logic [`NUM_SLOTS-1:0] req;
    sdram_addr_t           req_addr [`NUM_SLOTS];
    logic [`NUM_SLOTS-1:0] word_valid;
    logic [`NUM_SLOTS-1:0] done;
    sdram_word_t           word_data;

    sdram_slot #(
        .payload_t   ( main_rom_data_t      ),
        .region_base ( `MAIN_ROM_BASE       )
    ) u_main_slot (
        .VB          ( VB                   ),
        .reset       ( reset                ),
        .cs          ( main_rom_cs          ),
        .addr        ( main_rom_addr        ),
        .data        ( main_rom_data        ),
        .ok          ( main_rom_ok          ),
        .req         ( req[main_slot]       ),
        .req_addr    ( req_addr[main_slot]  ),
        .word_valid  ( word_valid[main_slot]),
        .word_data   ( word_data            ),
        .done        ( done[main_slot]      )
    );

    sdram_slot #(
        .payload_t   ( gfx_rom_data_t       ),
        .region_base ( `GFX_ROM_BASE        )
    ) u_gfx_slot (
        .VB          ( VB                   ),
        .reset       ( reset                ),
        .cs          ( gfx_rom_cs           ),
        .addr        ( gfx_rom_addr         ),
        .data        ( gfx_rom_data         ),
        .ok          ( gfx_rom_ok           ),
        .req         ( req[gfx_slot]        ),
        .req_addr    ( req_addr[gfx_slot]   ),
        .word_valid  ( word_valid[gfx_slot] ),
        .word_data   ( word_data            ),
        .done        ( done[gfx_slot]       )
    );

    sdram_slot #(
        .payload_t   ( pcm_data_t           ),
        .region_base ( `PCM_ROM_BASE        )
    ) u_pcm_slot (
        .VB          ( VB                   ),
        .reset       ( reset                ),
        .cs          ( pcm_cs               ),
        .addr        ( pcm_addr             ),
        .data        ( pcm_data             ),
        .ok          ( pcm_ok               ),
        .req         ( req[pcm_slot]        ),
        .req_addr    ( req_addr[pcm_slot]   ),
        .word_valid  ( word_valid[pcm_slot] ),
        .word_data   ( word_data            ),
        .done        ( done[pcm_slot]       )
    );

    sdram_arbiter #(
        .two_word_slots ( gfx_mask   )
    ) u_arbiter (
        .VB             ( VB         ),
        .reset          ( reset      ),
        .req            ( req        ),
        .req_addr       ( req_addr   ),
        .word_valid     ( word_valid ),
        .done           ( done       ),
        .word_data      ( word_data  ),
        .ba_addr        ( ba_addr    ),
        .ba_rd          ( ba_rd      ),
        .ba_ack         ( ba_ack     ),
        .ba_dok         ( ba_dok     ),
        .ba_rdy         ( ba_rdy     ),
        .data_read      ( data_read  )
    );

endmodule

// ==== bench/sdram_model.sv ====
// Module sdram_model, SDRAM bank read port with random latency and address-derived contents
`timescale 1ns/1ps
`include "game_sdram_defines.svh"

module sdram_model
    import sdram_pkg::*;
#(
    parameter logic [31:0] seed = 32'h9c30_cb07
) (
    input  logic        VB,
    input  logic        reset,
    input  sdram_addr_t ba_addr,
    input  logic        ba_rd,
    output logic        ba_ack,
    output logic        ba_dok,
    output logic        ba_rdy,
    output sdram_word_t data_read
);

    logic [31:0] lat_state;
    sdram_addr_t held_addr;

    // 0 to 5 cycles, taken from the upper LCG bits
    function automatic int next_latency();
        lat_state = lat_state * 32'd1664525 + 32'd1013904223;
        return int'(lat_state[31:16] % 16'd6);
    endfunction

    initial begin
        lat_state = seed;
        ba_ack    = 1'b0;
        ba_dok    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        forever begin
            @(negedge VB);
            if (!reset && ba_rd) begin
                repeat (next_latency()) @(negedge VB);
                held_addr = ba_addr;
                ba_ack    = 1'b1;
                @(negedge VB);
                ba_ack = 1'b0;
                repeat (next_latency()) @(negedge VB);
                // One word per request, so ba_rdy comes with ba_dok
                data_read = held_addr[15:0] ^ 16'hA5C3;
                ba_dok    = 1'b1;
                ba_rdy    = 1'b1;
                @(negedge VB);
                ba_dok = 1'b0;
                ba_rdy = 1'b0;
            end
        end
    end

endmodule

// ==== bench/game_sdram_props.sv ====
// Module game_sdram_props with bank-port and client-port assertions, and its bind into game_sdram
`timescale 1ns/1ps
`include "game_sdram_defines.svh"

module game_sdram_props (
    input logic                  VB,
    input logic                  reset,
    input logic                  ba_rd,
    input logic                  ba_ack,
    input logic                  ba_dok,
    input logic [`NUM_SLOTS-1:0] req,
    input logic [`NUM_SLOTS-1:0] word_valid,
    input logic                  main_rom_cs,
    input logic                  main_rom_ok,
    input logic                  gfx_rom_cs,
    input logic                  gfx_rom_ok,
    input logic                  pcm_cs,
    input logic                  pcm_ok
);

    int   assert_fails = 0;
    logic acked;

    function automatic void count_failure(input string msg);
        assert_fails++;
        $error("%s", msg);
    endfunction

    // Bank access open from ba_ack to its word
    always_ff @(posedge VB) begin
        if (reset) begin
            acked <= 1'b0;
        end else if (ba_rd && ba_ack) begin
            acked <= 1'b1;
        end else if (ba_dok) begin
            acked <= 1'b0;
        end
    end

    rd_held_until_ack: assert property (@(posedge VB) disable iff (reset)
        ba_rd && !ba_ack |=> ba_rd)
        else count_failure("ba_rd dropped before ba_ack");

    // Word strobe goes to a single slot, and only to one that is requesting
    one_word_target: assert property (@(posedge VB) disable iff (reset)
        $onehot0(word_valid) && ((word_valid & ~req) == '0))
        else count_failure("word_valid reached more than one slot or an idle slot");

    ok_needs_cs: assert property (@(posedge VB) disable iff (reset)
        (main_rom_cs || !main_rom_ok) && (gfx_rom_cs || !gfx_rom_ok) && (pcm_cs || !pcm_ok))
        else count_failure("ok high on a port without cs");

    dok_after_ack: assert property (@(posedge VB) disable iff (reset)
        ba_dok |-> acked)
        else count_failure("ba_dok with no acknowledged request");

endmodule

bind game_sdram game_sdram_props u_props (.*);

// ==== bench/game_sdram_tb.sv ====
// Testbench game_sdram_tb with clock, reset, random reads, reference model, checks and report
`timescale 1ns/1ps
`include "game_sdram_defines.svh"

module game_sdram_tb
    import sdram_pkg::*;
    import client_pkg::*;
();

    localparam int reset_cycles = 10;
    localparam int n_conc       = 40;
    // Single and repeated reads per port, then concurrent traffic
    localparam int n_txn        = 6 + 3 * n_conc;
    // Three graphics accesses at the slowest model latency
    localparam int max_wait     = 3 * 32;
    localparam int read_limit   = 4 * max_wait;

    logic           VB;
    logic           reset;
    logic [2:0]     cs;
    client_addr_t   addr [3];
    logic [2:0]     ok;
    logic [31:0]    data [3];
    main_rom_data_t main_data;
    gfx_rom_data_t  gfx_data;
    pcm_data_t      pcm_data;
    sdram_addr_t    ba_addr;
    logic           ba_rd;
    logic           ba_ack;
    logic           ba_dok;
    logic           ba_rdy;
    sdram_word_t    data_read;
    logic [31:0]    rand_state;
    sdram_addr_t    bank_log [$];
    int             errors;
    int             tests_run;
    int             tests_failed;

    // Port 0 main ROM, 1 graphics, 2 PCM
    game_sdram u_dut (
        .VB            (VB),
        .reset         (reset),
        .main_rom_cs   (cs[0]),
        .main_rom_addr (addr[0]),
        .main_rom_data (main_data),
        .main_rom_ok   (ok[0]),
        .gfx_rom_cs    (cs[1]),
        .gfx_rom_addr  (addr[1]),
        .gfx_rom_data  (gfx_data),
        .gfx_rom_ok    (ok[1]),
        .pcm_cs        (cs[2]),
        .pcm_addr      (addr[2]),
        .pcm_data      (pcm_data),
        .pcm_ok        (ok[2]),
        .ba_addr       (ba_addr),
        .ba_rd         (ba_rd),
        .ba_ack        (ba_ack),
        .ba_dok        (ba_dok),
        .ba_rdy        (ba_rdy),
        .data_read     (data_read)
    );

    sdram_model u_model (.*);

    assign data[0] = 32'(main_data);
    assign data[1] = gfx_data;
    assign data[2] = 32'(pcm_data);

    initial begin
        VB = 1'b0;
        forever begin
            #4;
            VB = ~VB;
        end
    end

    // Every accepted bank request, in order
    always @(posedge VB) begin
        if (!reset && ba_rd && ba_ack) begin
            bank_log.push_back(ba_addr);
        end
    end

    initial begin
        repeat (n_txn * `NUM_SLOTS * 20 + reset_cycles) @(posedge VB);
        $display("watchdog expired at %0t, run stopped", $time);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, rand_state[31:8]};
    endfunction

    function automatic sdram_word_t rom_word(input sdram_addr_t a);
        return a[15:0] ^ 16'hA5C3;
    endfunction

    // First bank word of a client address, by region
    function automatic sdram_addr_t first_word(input int port, input client_addr_t a);
        case (port)
            0: return `MAIN_ROM_BASE + sdram_addr_t'(a);
            1: return `GFX_ROM_BASE + 2 * sdram_addr_t'(a);
            default: return `PCM_ROM_BASE + sdram_addr_t'(a >> 1);
        endcase
    endfunction

    function automatic logic [31:0] expected_data(input int port, input client_addr_t a);
        sdram_addr_t wa;
        sdram_word_t w;
        wa = first_word(port, a);
        w  = rom_word(wa);
        case (port)
            0: return 32'(w);
            1: return {rom_word(wa + 1'b1), w};
            default: return a[0] ? 32'(w[15:8]) : 32'(w[7:0]);
        endcase
    endfunction

    // Raise cs with addr, wait for ok and compare the payload
    task automatic read_port(input int port, input client_addr_t a, output int cycles);
        logic [31:0] exp;
        @(negedge VB);
        cs[port]   = 1'b1;
        addr[port] = a;
        cycles     = 0;
        do begin
            @(posedge VB);
            cycles++;
        end while (!ok[port] && cycles < read_limit);
        exp = expected_data(port, a);
        if (!ok[port]) begin
            $display("port %0d read of %h got no ok within %0d cycles at %0t",
                     port, a, cycles, $time);
            errors++;
        end else if (data[port] !== exp) begin
            $display("mismatch at %0t: port %0d address %h read %h, expected %h",
                     $time, port, a, data[port], exp);
            errors++;
        end
    endtask

    task automatic release_port(input int port);
        @(negedge VB);
        cs[port] = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, errors - err_start);
    endtask

    // Miss, held hit and repeated hit on one port, with the bank requests they cause
    task automatic port_reads(input int port);
        client_addr_t a;
        sdram_addr_t  first;
        int           cycles;
        int           n_bank;
        int           err_start;
        err_start = errors;
        a         = client_addr_t'(next_rand());
        first     = first_word(port, a);
        bank_log.delete();
        read_port(port, a, cycles);
        repeat (2) begin
            @(posedge VB);
            if (!ok[port]) begin
                $display("mismatch at %0t: port %0d ok fell with cs and addr held", $time, port);
                errors++;
            end
        end
        release_port(port);
        if (bank_log.size() != ((port == 1) ? 2 : 1)) begin
            $display("mismatch at %0t: port %0d read made %0d bank requests",
                     $time, port, bank_log.size());
            errors++;
        end
        foreach (bank_log[i]) begin
            if (bank_log[i] != first + sdram_addr_t'(i)) begin
                $display("mismatch at %0t: bank request %0d at %h, expected %h",
                         $time, i, bank_log[i], first + sdram_addr_t'(i));
                errors++;
            end
        end
        n_bank = bank_log.size();
        read_port(port, a, cycles);
        release_port(port);
        if (bank_log.size() != n_bank || cycles != 1) begin
            $display("mismatch at %0t: repeated read on port %0d took %0d cycles, %0d requests",
                     $time, port, cycles, bank_log.size() - n_bank);
            errors++;
        end
        report_test($sformatf("port %0d reads", port), err_start);
    endtask

    task automatic client_traffic(input int port);
        int cycles;
        repeat (n_conc) begin
            read_port(port, client_addr_t'(next_rand()), cycles);
            if (ok[port] && cycles > max_wait) begin
                $display("port %0d waited %0d cycles for ok, over the bound of %0d, at %0t",
                         port, cycles, max_wait, $time);
                errors++;
            end
            release_port(port);
        end
    endtask

    initial begin
        int err_start;
        rand_state   = 32'h9c30_cb07;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        cs           = '0;
        foreach (addr[i]) begin
            addr[i] = '0;
        end
        repeat (reset_cycles) @(posedge VB);
        @(negedge VB);
        reset = 1'b0;
        @(posedge VB);
        err_start = errors;
        if (ok != 3'b000 || ba_rd) begin
            $display("mismatch at %0t: ok %b ba_rd %b before any cs", $time, ok, ba_rd);
            errors++;
        end
        report_test("reset", err_start);
        for (int port = 0; port < 3; port++) begin
            port_reads(port);
        end
        err_start = errors;
        fork
            client_traffic(0);
            client_traffic(1);
            client_traffic(2);
        join
        report_test("concurrent", err_start);
        if (u_dut.u_props.assert_fails != 0) begin
            $display("bound checker saw %0d assertion failures", u_dut.u_props.assert_fails);
            errors += u_dut.u_props.assert_fails;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== game_sdram.f ====
+incdir+include
hw/sdram_pkg.sv
hw/client_pkg.sv
hw/sdram_slot.sv
hw/sdram_arbiter.sv
hw/game_sdram.sv
bench/sdram_model.sv
bench/game_sdram_props.sv
bench/game_sdram_tb.sv

// ==== Bender.yml ====
package:
  name: game_sdram

export_include_dirs:
  - include

sources:
  - hw/sdram_pkg.sv
  - hw/client_pkg.sv
  - hw/sdram_slot.sv
  - hw/sdram_arbiter.sv
  - hw/game_sdram.sv
  - target: test
    files:
      - bench/sdram_model.sv
      - bench/game_sdram_props.sv
      - bench/game_sdram_tb.sv
